// File: common/id_defines.svh
`ifndef ID_DEFINES_SVH
`define ID_DEFINES_SVH

// data path and pc width
`define ID_XLEN 32

// architectural register index width
`define ID_REG_AW 5

// decoded immediate width
`define ID_IMM_W 32

`endif

// File: common/isa_pkg.sv
`default_nettype none

`include "id_defines.svh"

package isa_pkg;

  typedef logic [`ID_REG_AW-1:0] reg_addr_t;

  // one-hot alu select, add sits in bit 0
  typedef struct packed {
    logic lui;
    logic sra;
    logic srl;
    logic sll;
    logic op_xor;
    logic op_or;
    logic op_nor;
    logic op_and;
    logic sltu;
    logic slt;
    logic sub;
    logic add;
  } alu_op_t;

  // byte enables of a load or store
  typedef enum logic [3:0] {
    MW_NONE = 4'b0000,
    MW_BYTE = 4'b0001,
    MW_HALF = 4'b0011,
    MW_WORD = 4'b1111
  } mem_width_t;

  typedef struct packed {
    logic may_jump;
    logic use_rj_value;
    logic use_less;
    logic need_less;
    logic use_zero;
    logic need_zero;
    logic is_bl;
    logic is_jirl;
  } branch_t;

endpackage

`default_nettype wire

// File: common/pipe_pkg.sv
`default_nettype none

`include "id_defines.svh"

package pipe_pkg;

  import isa_pkg::*;

  typedef struct packed {
    logic [`ID_XLEN-1:0] pc;
    logic [31:0]         instr;
  } fetch_slot_t;

  // result bus from execute, checked against source registers
  typedef struct packed {
    logic                valid;
    logic                gr_we;
    reg_addr_t           dest;
    logic [`ID_XLEN-1:0] data;
  } fwd_bus_t;

  typedef struct packed {
    logic [`ID_XLEN-1:0]  pc;
    alu_op_t              alu_op;
    mem_width_t           mem_width;
    logic                 mem_we;
    logic                 res_from_mem;
    branch_t              branch;
    logic                 src1_is_pc;
    logic                 src2_is_imm;
    logic                 src2_is_4;
    logic                 gr_we;
    reg_addr_t            dest;
    logic [`ID_IMM_W-1:0] imm;
    logic [`ID_XLEN-1:0]  rj_value;
    logic [`ID_XLEN-1:0]  rkd_value;
    logic                 use_mul;
    logic                 use_high;
    logic                 is_unsigned;
    logic                 use_div;
    logic                 use_mod;
  } uop_t;

  // what the pair check needs to know about one slot
  typedef struct packed {
    reg_addr_t dest;
    logic      gr_we;
    logic      use_rj;
    logic      use_rkd;
    reg_addr_t rj;
    reg_addr_t rkd;
    logic      is_ls;
    logic      is_mul;
    logic      is_div;
    logic      may_jump;
    logic      unknown;
  } hazard_t;

endpackage

`default_nettype wire

// File: decode/operand_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_defines.svh"

module operand_select
  import isa_pkg::*;
  import pipe_pkg::*;
(
  input  reg_addr_t           raddr,
  input  logic [`ID_XLEN-1:0] rf_rdata,
  input  fwd_bus_t            fwd_old,
  input  fwd_bus_t            fwd_young,
  output logic [`ID_XLEN-1:0] value
);

  logic young_hit;
  logic old_hit;

  assign young_hit = fwd_young.valid && fwd_young.gr_we && fwd_young.dest == raddr;
  assign old_hit   = fwd_old.valid && fwd_old.gr_we && fwd_old.dest == raddr;

  // younger result is the newer value of the register
  always_comb
  begin
    if (young_hit)
      value = fwd_young.data;
    else if (old_hit)
      value = fwd_old.data;
    else
      value = rf_rdata;
  end

endmodule

`default_nettype wire

// File: decode/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_defines.svh"

module instr_decoder
  import isa_pkg::*;
  import pipe_pkg::*;
(
  input  fetch_slot_t         slot,
  output reg_addr_t           rf_raddr_rj,
  output reg_addr_t           rf_raddr_rkd,
  input  logic [`ID_XLEN-1:0] rf_rdata_rj,
  input  logic [`ID_XLEN-1:0] rf_rdata_rkd,
  input  fwd_bus_t            fwd_old,
  input  fwd_bus_t            fwd_young,
  output uop_t                uop,
  output hazard_t             hazard
);

  logic [31:0] ins;
  logic [5:0]  op_31_26;
  logic [3:0]  op_25_22;
  logic [1:0]  op_21_20;
  logic [4:0]  op_19_15;
  reg_addr_t   rd;
  reg_addr_t   rj;
  reg_addr_t   rk;
  logic        grp_3r;
  logic        grp_div;
  logic        grp_shi;
  logic        grp_2ri;
  logic        grp_mem;
  logic        add_w, sub_w, slt, sltu, nor_w, and_w, or_w, xor_w;
  logic        sll_w, srl_w, sra_w, slli_w, srli_w, srai_w;
  logic        addi_w, slti, sltui, andi, ori, xori, lu12i_w, pcaddu;
  logic        mul_w, mulh_w, mulhu_w, div_w, mod_w, divu_w, modu_w;
  logic        ld_b, ld_h, ld_w, ld_bu, ld_hu, st_b, st_h, st_w;
  logic        jirl, b_j, bl, beq, bne, blt, bge, bltu, bgeu;
  logic        is_store;
  logic        is_cond_br;
  logic        known;
  alu_op_t     alu_op;
  mem_width_t  mem_width;
  branch_t     branch;
  logic        src2_is_imm;
  logic        src1_is_pc;
  logic        src2_is_4;
  reg_addr_t   dest;
  logic [`ID_IMM_W-1:0] imm;
  logic [`ID_XLEN-1:0]  rj_value;
  logic [`ID_XLEN-1:0]  rkd_value;

  assign ins      = slot.instr;
  assign op_31_26 = ins[31:26];
  assign op_25_22 = ins[25:22];
  assign op_21_20 = ins[21:20];
  assign op_19_15 = ins[19:15];
  assign rd       = ins[4:0];
  assign rj       = ins[9:5];
  assign rk       = ins[14:10];

  // major opcode groups
  assign grp_2ri = op_31_26 == 6'h00;
  assign grp_3r  = grp_2ri && op_25_22 == 4'h0 && op_21_20 == 2'h1;
  assign grp_div = grp_2ri && op_25_22 == 4'h0 && op_21_20 == 2'h2;
  assign grp_shi = grp_2ri && op_25_22 == 4'h1 && op_21_20 == 2'h0;
  assign grp_mem = op_31_26 == 6'h0a;

  assign add_w   = grp_3r && op_19_15 == 5'h00;
  assign sub_w   = grp_3r && op_19_15 == 5'h02;
  assign slt     = grp_3r && op_19_15 == 5'h04;
  assign sltu    = grp_3r && op_19_15 == 5'h05;
  assign nor_w   = grp_3r && op_19_15 == 5'h08;
  assign and_w   = grp_3r && op_19_15 == 5'h09;
  assign or_w    = grp_3r && op_19_15 == 5'h0a;
  assign xor_w   = grp_3r && op_19_15 == 5'h0b;
  assign sll_w   = grp_3r && op_19_15 == 5'h0e;
  assign srl_w   = grp_3r && op_19_15 == 5'h0f;
  assign sra_w   = grp_3r && op_19_15 == 5'h10;
  assign mul_w   = grp_3r && op_19_15 == 5'h18;
  assign mulh_w  = grp_3r && op_19_15 == 5'h19;
  assign mulhu_w = grp_3r && op_19_15 == 5'h1a;
  assign div_w   = grp_div && op_19_15 == 5'h00;
  assign mod_w   = grp_div && op_19_15 == 5'h01;
  assign divu_w  = grp_div && op_19_15 == 5'h02;
  assign modu_w  = grp_div && op_19_15 == 5'h03;
  assign slli_w  = grp_shi && op_19_15 == 5'h01;
  assign srli_w  = grp_shi && op_19_15 == 5'h09;
  assign srai_w  = grp_shi && op_19_15 == 5'h11;
  assign slti    = grp_2ri && op_25_22 == 4'h8;
  assign sltui   = grp_2ri && op_25_22 == 4'h9;
  assign addi_w  = grp_2ri && op_25_22 == 4'ha;
  assign andi    = grp_2ri && op_25_22 == 4'hd;
  assign ori     = grp_2ri && op_25_22 == 4'he;
  assign xori    = grp_2ri && op_25_22 == 4'hf;
  assign lu12i_w = op_31_26 == 6'h05 && !ins[25];
  assign pcaddu  = op_31_26 == 6'h07 && !ins[25];
  assign ld_b    = grp_mem && op_25_22 == 4'h0;
  assign ld_h    = grp_mem && op_25_22 == 4'h1;
  assign ld_w    = grp_mem && op_25_22 == 4'h2;
  assign st_b    = grp_mem && op_25_22 == 4'h4;
  assign st_h    = grp_mem && op_25_22 == 4'h5;
  assign st_w    = grp_mem && op_25_22 == 4'h6;
  assign ld_bu   = grp_mem && op_25_22 == 4'h8;
  assign ld_hu   = grp_mem && op_25_22 == 4'h9;
  assign jirl    = op_31_26 == 6'h13;
  assign b_j     = op_31_26 == 6'h14;
  assign bl      = op_31_26 == 6'h15;
  assign beq     = op_31_26 == 6'h16;
  assign bne     = op_31_26 == 6'h17;
  assign blt     = op_31_26 == 6'h18;
  assign bge     = op_31_26 == 6'h19;
  assign bltu    = op_31_26 == 6'h1a;
  assign bgeu    = op_31_26 == 6'h1b;

  assign is_store   = st_b | st_h | st_w;
  assign is_cond_br = beq | bne | blt | bge | bltu | bgeu;

  assign known = add_w | sub_w | slt | sltu | nor_w | and_w | or_w | xor_w
               | sll_w | srl_w | sra_w | slli_w | srli_w | srai_w
               | addi_w | slti | sltui | andi | ori | xori | lu12i_w | pcaddu
               | mul_w | mulh_w | mulhu_w | div_w | mod_w | divu_w | modu_w
               | ld_b | ld_h | ld_w | ld_bu | ld_hu | is_store
               | jirl | b_j | bl | is_cond_br;

  // address calc and link use the adder, compares use sub/slt
  assign alu_op.add    = add_w | addi_w | grp_mem | jirl | bl | pcaddu;
  assign alu_op.sub    = sub_w | beq | bne;
  assign alu_op.slt    = slt | slti | blt | bge;
  assign alu_op.sltu   = sltu | sltui | bltu | bgeu;
  assign alu_op.op_and = and_w | andi;
  assign alu_op.op_nor = nor_w;
  assign alu_op.op_or  = or_w | ori;
  assign alu_op.op_xor = xor_w | xori;
  assign alu_op.sll    = sll_w | slli_w;
  assign alu_op.srl    = srl_w | srli_w;
  assign alu_op.sra    = sra_w | srai_w;
  assign alu_op.lui    = lu12i_w;

  assign mem_width = (ld_w | st_w)          ? MW_WORD :
                     (ld_h | ld_hu | st_h) ? MW_HALF :
                     (ld_b | ld_bu | st_b) ? MW_BYTE : MW_NONE;

  assign branch.may_jump     = is_cond_br | jirl | b_j | bl;
  assign branch.use_rj_value = jirl;
  assign branch.use_less     = blt | bge | bltu | bgeu;
  assign branch.need_less    = blt | bltu;
  assign branch.use_zero     = beq | bne;
  assign branch.need_zero    = beq;
  assign branch.is_bl        = bl;
  assign branch.is_jirl      = jirl;

  assign src1_is_pc  = jirl | bl | pcaddu;
  assign src2_is_4   = jirl | bl;
  assign src2_is_imm = slli_w | srli_w | srai_w | addi_w | slti | sltui
                     | andi | ori | xori | lu12i_w | pcaddu | grp_mem;

  // ui5, si20<<12, si26, si16, zero-extended ui12, si12
  always_comb
  begin
    if (lu12i_w | pcaddu)
      imm = {ins[24:5], 12'b0};
    else if (slli_w | srli_w | srai_w)
      imm = {{(`ID_IMM_W-5){1'b0}}, rk};
    else if (b_j | bl)
      imm = {{(`ID_IMM_W-26){ins[9]}}, ins[9:0], ins[25:10]};
    else if (jirl | is_cond_br)
      imm = {{(`ID_IMM_W-16){ins[25]}}, ins[25:10]};
    else if (andi | ori | xori)
      imm = {{(`ID_IMM_W-12){1'b0}}, ins[21:10]};
    else
      imm = {{(`ID_IMM_W-12){ins[21]}}, ins[21:10]};
  end

  assign dest         = bl ? reg_addr_t'(1) : rd;
  assign rf_raddr_rj  = rj;
  assign rf_raddr_rkd = (is_store | is_cond_br) ? rd : rk;

  operand_select u_sel_rj (
    .raddr     (rf_raddr_rj),
    .rf_rdata  (rf_rdata_rj),
    .fwd_old   (fwd_old),
    .fwd_young (fwd_young),
    .value     (rj_value)
  );

  operand_select u_sel_rkd (
    .raddr     (rf_raddr_rkd),
    .rf_rdata  (rf_rdata_rkd),
    .fwd_old   (fwd_old),
    .fwd_young (fwd_young),
    .value     (rkd_value)
  );

  always_comb
  begin
    uop.pc           = slot.pc;
    uop.alu_op       = alu_op;
    uop.mem_width    = mem_width;
    uop.mem_we       = is_store;
    uop.res_from_mem = grp_mem & ~is_store & known;
    uop.branch       = branch;
    uop.src1_is_pc   = src1_is_pc;
    uop.src2_is_imm  = src2_is_imm;
    uop.src2_is_4    = src2_is_4;
    uop.gr_we        = ~is_store & ~is_cond_br & ~b_j & (dest != '0);
    uop.dest         = dest;
    uop.imm          = imm;
    uop.rj_value     = rj_value;
    uop.rkd_value    = rkd_value;
    uop.use_mul      = mul_w | mulh_w | mulhu_w;
    uop.use_high     = mulh_w | mulhu_w;
    uop.is_unsigned  = mulhu_w | divu_w | modu_w | ld_bu | ld_hu;
    uop.use_div      = div_w | mod_w | divu_w | modu_w;
    uop.use_mod      = mod_w | modu_w;
  end

  always_comb
  begin
    hazard.dest     = dest;
    hazard.gr_we    = uop.gr_we;
    // pc-relative forms and the long jumps never read rj
    hazard.use_rj   = jirl | ~(src1_is_pc | b_j | lu12i_w);
    hazard.use_rkd  = (~(src2_is_4 | src2_is_imm) & ~b_j) | is_store;
    hazard.rj       = rf_raddr_rj;
    hazard.rkd      = rf_raddr_rkd;
    hazard.is_ls    = mem_width != MW_NONE;
    hazard.is_mul   = uop.use_mul;
    hazard.is_div   = uop.use_div;
    hazard.may_jump = branch.may_jump;
    hazard.unknown  = ~known;
  end

  // every kept encoding selects a single alu function or none
  a_alu_onehot: assert final ($isunknown(ins) || $onehot0(alu_op))
    else $error("alu_op not one-hot for instr %h", ins);

endmodule

`default_nettype wire

// File: verilog/pair_check.sv
`timescale 1ns/1ps
`default_nettype none

module pair_check
  import pipe_pkg::*;
(
  input  hazard_t hz0,
  input  hazard_t hz1,
  output logic    need_single
);

  logic slot0_ctrl;
  logic jump_behind_long;
  logic ls_behind_muldiv;
  logic same_unit;
  logic raw_rj;
  logic raw_rkd;
  logic raw;

  // slot 0 control flow or memory access always goes alone
  assign slot0_ctrl = hz0.may_jump | hz0.is_ls;

  assign jump_behind_long = hz1.may_jump & (hz0.is_ls | hz0.is_mul | hz0.is_div);
  assign ls_behind_muldiv = hz1.is_ls & (hz0.is_mul | hz0.is_div);

  // only one multiplier and one divider
  assign same_unit = (hz0.is_mul & hz1.is_mul) | (hz0.is_div & hz1.is_div);

  assign raw_rj  = hz1.use_rj && hz1.rj == hz0.dest;
  assign raw_rkd = hz1.use_rkd && hz1.rkd == hz0.dest;
  assign raw     = hz0.gr_we && hz0.dest != '0 && (raw_rj || raw_rkd);

  assign need_single = slot0_ctrl
                     | jump_behind_long
                     | ls_behind_muldiv
                     | same_unit
                     | hz0.unknown
                     | hz1.unknown
                     | raw;

endmodule

`default_nettype wire

// File: verilog/issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_defines.svh"

module issue_stage
  import isa_pkg::*;
  import pipe_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  fetch_slot_t         slot0,
  input  fetch_slot_t         slot1,
  input  logic                slot0_valid,
  input  logic                slot1_valid,
  output logic [1:0]          pop,
  output reg_addr_t           rf_raddr [4],
  input  logic [`ID_XLEN-1:0] rf_rdata [4],
  input  fwd_bus_t            fwd_old,
  input  fwd_bus_t            fwd_young,
  input  logic                exe_ready,
  input  logic                flush,
  output uop_t                uop0,
  output uop_t                uop1,
  output logic                uop0_valid,
  output logic                uop1_valid
);

  uop_t    dec_uop0;
  uop_t    dec_uop1;
  hazard_t hz0;
  hazard_t hz1;
  logic    need_single;
  logic    issue0;
  logic    issue1;

  instr_decoder u_dec0 (
    .slot         (slot0),
    .rf_raddr_rj  (rf_raddr[0]),
    .rf_raddr_rkd (rf_raddr[1]),
    .rf_rdata_rj  (rf_rdata[0]),
    .rf_rdata_rkd (rf_rdata[1]),
    .fwd_old      (fwd_old),
    .fwd_young    (fwd_young),
    .uop          (dec_uop0),
    .hazard       (hz0)
  );

  instr_decoder u_dec1 (
    .slot         (slot1),
    .rf_raddr_rj  (rf_raddr[2]),
    .rf_raddr_rkd (rf_raddr[3]),
    .rf_rdata_rj  (rf_rdata[2]),
    .rf_rdata_rkd (rf_rdata[3]),
    .fwd_old      (fwd_old),
    .fwd_young    (fwd_young),
    .uop          (dec_uop1),
    .hazard       (hz1)
  );

  pair_check u_pair (
    .hz0         (hz0),
    .hz1         (hz1),
    .need_single (need_single)
  );

  assign issue0 = slot0_valid;
  assign issue1 = slot1_valid & ~need_single;
  assign pop    = {issue1 & exe_ready, issue0 & exe_ready};

  // flush beats a stall
  always_ff @(posedge clk)
  begin
    if (rst || flush)
    begin
      uop0_valid <= 1'b0;
      uop1_valid <= 1'b0;
    end
    else if (exe_ready)
    begin
      uop0_valid <= issue0;
      uop1_valid <= issue1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (exe_ready)
    begin
      uop0 <= dec_uop0;
      uop1 <= dec_uop1;
    end
  end

  a_no_pop_stalled: assert property (@(posedge clk) !exe_ready |-> pop == 2'b00)
    else $error("pop while execute not ready");

  a_clear_valid: assert property (@(posedge clk)
    (rst || flush) |=> (!uop0_valid && !uop1_valid))
    else $error("issue register valid after reset or flush");

  // a stalled pair must reach execute unchanged
  a_hold_stall: assert property (@(posedge clk) disable iff (rst)
    (!exe_ready && !flush) |=> ($stable(uop0_valid) && $stable(uop1_valid)
      && (!uop0_valid || $stable(uop0)) && (!uop1_valid || $stable(uop1))))
    else $error("issue register changed during stall");

endmodule

`default_nettype wire

// File: test/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock
(
  output logic clk,
  output logic rst
);

  localparam int RST_CYCLES = 8;

  // 40 ns period
  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial
  begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    #1 rst = 1'b0;
  end

endmodule

`default_nettype wire

// File: test/issue_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_defines.svh"

module issue_stage_tb
  import isa_pkg::*;
  import pipe_pkg::*;
();

  typedef enum {K_ADDI, K_ADD, K_XOR, K_MUL, K_LDW, K_LDB, K_STW, K_STH,
                K_BEQ, K_BLT, K_BL, K_UNK} kind_t;

  // the uop fields that the checks look at
  typedef struct packed {
    alu_op_t              alu_op;
    mem_width_t           mem_width;
    logic                 mem_we;
    logic                 res_from_mem;
    branch_t              branch;
    logic                 gr_we;
    reg_addr_t            dest;
    logic [`ID_IMM_W-1:0] imm;
    logic [`ID_XLEN-1:0]  rj_value;
    logic [`ID_XLEN-1:0]  rkd_value;
  } view_t;

  // reset plus the stimulus cycles below
  localparam int STIM_CYCLES = 30;
  localparam int CYCLE_LIMIT = 2 * STIM_CYCLES + 20;

  logic                clk;
  logic                rst;
  fetch_slot_t         slot0;
  fetch_slot_t         slot1;
  logic                slot0_valid;
  logic                slot1_valid;
  logic [1:0]          pop;
  reg_addr_t           rf_raddr [4];
  logic [`ID_XLEN-1:0] rf_rdata [4];
  fwd_bus_t            fwd_old;
  fwd_bus_t            fwd_young;
  logic                exe_ready;
  logic                flush;
  uop_t                uop0;
  uop_t                uop1;
  logic                uop0_valid;
  logic                uop1_valid;

  logic [31:0] rng;
  int          cycles = 0;
  int          mism;
  int          other;
  logic [1:0]  exp_pop;
  logic [1:0]  exp_v;
  logic [1:0]  exp_v_q;
  view_t       next_u [2];
  view_t       exp_u [2];
  view_t       exp_u_q [2];
  logic [1:0]  next_care;
  logic [1:0]  care;
  logic [1:0]  care_q;
  logic [1:0]  next_chk;
  logic [1:0]  chk_u;
  logic [1:0]  chk_u_q;
  view_t       act_u0;
  view_t       act_u1;

  tb_clock u_clock (
    .clk (clk),
    .rst (rst)
  );

  issue_stage DUT (
    .clk         (clk),
    .rst         (rst),
    .slot0       (slot0),
    .slot1       (slot1),
    .slot0_valid (slot0_valid),
    .slot1_valid (slot1_valid),
    .pop         (pop),
    .rf_raddr    (rf_raddr),
    .rf_rdata    (rf_rdata),
    .fwd_old     (fwd_old),
    .fwd_young   (fwd_young),
    .exe_ready   (exe_ready),
    .flush       (flush),
    .uop0        (uop0),
    .uop1        (uop1),
    .uop0_valid  (uop0_valid),
    .uop1_valid  (uop1_valid)
  );

  function automatic logic [31:0] xorshift();
    logic [31:0] x;
    x = rng;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng = x;
    return x;
  endfunction

  function automatic reg_addr_t low_reg();
    return reg_addr_t'(1 + xorshift() % 15);
  endfunction

  function automatic reg_addr_t high_reg();
    return reg_addr_t'(16 + xorshift() % 16);
  endfunction

  // r0 reads as zero
  function automatic logic [31:0] rf_model(reg_addr_t a);
    return (a == '0) ? '0 : 32'h9e37_79b9 * {27'b0, a};
  endfunction

  function automatic logic [31:0] forwarded_value(reg_addr_t a);
    if (fwd_young.valid && fwd_young.gr_we && fwd_young.dest == a)
      return fwd_young.data;
    if (fwd_old.valid && fwd_old.gr_we && fwd_old.dest == a)
      return fwd_old.data;
    return rf_model(a);
  endfunction

  always_comb
  begin
    for (int i = 0; i < 4; i++)
      rf_rdata[i] = rf_model(rf_raddr[i]);
  end

  function automatic logic [31:0] encode(kind_t k, reg_addr_t rd, reg_addr_t rj,
                                         reg_addr_t rk, logic [31:0] r);
    case (k)
      K_ADDI:  return {10'h00a, r[11:0], rj, rd};
      K_ADD:   return {17'h00020, rk, rj, rd};
      K_XOR:   return {17'h0002b, rk, rj, rd};
      K_MUL:   return {17'h00038, rk, rj, rd};
      K_LDW:   return {10'h0a2, r[11:0], rj, rd};
      K_LDB:   return {10'h0a0, r[11:0], rj, rd};
      K_STW:   return {10'h0a6, r[11:0], rj, rd};
      K_STH:   return {10'h0a5, r[11:0], rj, rd};
      K_BEQ:   return {6'h16, r[15:0], rj, rd};
      K_BLT:   return {6'h18, r[15:0], rj, rd};
      K_BL:    return {6'h15, r[15:0], r[25:16]};
      default: return 32'hffff_ffff;
    endcase
  endfunction

  function automatic view_t expected_uop(kind_t k, logic [31:0] ins, logic [31:0] r);
    view_t     v;
    logic      st;
    logic      br;
    reg_addr_t kd;
    st = k inside {K_STW, K_STH};
    br = k inside {K_BEQ, K_BLT};
    // stores and compares read rd as second source
    kd = (st || br) ? ins[4:0] : ins[14:10];
    v = '0;
    v.dest = (k == K_BL) ? reg_addr_t'(1) : ins[4:0];
    v.gr_we = !st && !br && v.dest != '0;
    v.rj_value = forwarded_value(ins[9:5]);
    v.rkd_value = forwarded_value(kd);
    v.mem_we = st;
    v.res_from_mem = k inside {K_LDW, K_LDB};
    v.imm = {{20{r[11]}}, r[11:0]};
    if (k inside {K_ADDI, K_ADD, K_LDW, K_LDB, K_STW, K_STH, K_BL})
      v.alu_op.add = 1'b1;
    case (k)
      K_XOR:        v.alu_op.op_xor = 1'b1;
      K_LDW, K_STW: v.mem_width = MW_WORD;
      K_LDB:        v.mem_width = MW_BYTE;
      K_STH:        v.mem_width = MW_HALF;
      K_BEQ:
      begin
        v.alu_op.sub = 1'b1;
        v.branch = branch_t'(8'b1000_1100);
        v.imm = {{16{r[15]}}, r[15:0]};
      end
      K_BLT:
      begin
        v.alu_op.slt = 1'b1;
        v.branch = branch_t'(8'b1011_0000);
        v.imm = {{16{r[15]}}, r[15:0]};
      end
      K_BL:
      begin
        v.branch = branch_t'(8'b1000_0010);
        v.imm = {{6{r[25]}}, r[25:0]};
      end
      default: ;
    endcase
    return v;
  endfunction

  function automatic view_t view_of(uop_t u);
    view_t v;
    v.alu_op = u.alu_op;
    v.mem_width = u.mem_width;
    v.mem_we = u.mem_we;
    v.res_from_mem = u.res_from_mem;
    v.branch = u.branch;
    v.gr_we = u.gr_we;
    v.dest = u.dest;
    v.imm = u.imm;
    v.rj_value = u.rj_value;
    v.rkd_value = u.rkd_value;
    return v;
  endfunction

  // register-register forms carry no immediate
  function automatic view_t masked(view_t v, logic imm_care);
    if (!imm_care)
      v.imm = '0;
    return v;
  endfunction

  assign act_u0 = view_of(uop0);
  assign act_u1 = view_of(uop1);

  task automatic load_slot(int idx, kind_t k, reg_addr_t rd, reg_addr_t rj, reg_addr_t rk);
    logic [31:0] r;
    logic [31:0] ins;
    r = xorshift();
    ins = encode(k, rd, rj, rk, r);
    if (idx == 0)
      slot0 = '{pc: 32'h1c00_0000, instr: ins};
    else
      slot1 = '{pc: 32'h1c00_0004, instr: ins};
    next_u[idx] = expected_uop(k, ins, r);
    next_care[idx] = !(k inside {K_ADD, K_XOR, K_MUL});
    next_chk[idx] = k != K_UNK;
  endtask

  // drive one cycle, then wait until 1 ns past the next edge
  task automatic drive_cycle(logic [1:0] v, logic single, logic ready, logic fl);
    slot0_valid = v[0];
    slot1_valid = v[1];
    exe_ready = ready;
    flush = fl;
    exp_pop = ready ? {v[1] & ~single, v[0]} : 2'b00;
    if (fl)
      exp_v = 2'b00;
    else if (ready)
      exp_v = {v[1] & ~single, v[0]};
    if (ready)
    begin
      exp_u = next_u;
      care = next_care;
      chk_u = next_chk;
    end
    @(posedge clk);
    #1;
  endtask

  task automatic report_mismatch(string name, logic [127:0] exp, logic [127:0] act);
    mism++;
    $display("MISMATCH at %0t: %s expected %0h, got %0h", $time, name, exp, act);
  endtask

  always @(posedge clk)
  begin
    exp_v_q <= exp_v;
    exp_u_q <= exp_u;
    care_q <= care;
    chk_u_q <= chk_u;
    cycles <= cycles + 1;
    if (cycles == CYCLE_LIMIT)
    begin
      $display("run stopped after %0d cycles before the stimulus ended", cycles);
      $display("errors: %0d mismatches, %0d other failures", mism, other + 1);
      $display("tests failed");
      $finish;
    end
  end

  a_pop: assert property (@(posedge clk) cycles > 0 |-> pop == exp_pop)
    else report_mismatch("pop", $sampled(exp_pop), $sampled(pop));

  a_valid: assert property (@(posedge clk)
    cycles > 1 |-> {uop1_valid, uop0_valid} == exp_v_q)
    else report_mismatch("uop_valid", $sampled(exp_v_q), $sampled({uop1_valid, uop0_valid}));

  a_uop0: assert property (@(posedge clk) (cycles > 1 && exp_v_q[0] && chk_u_q[0])
    |-> masked(act_u0, care_q[0]) == masked(exp_u_q[0], care_q[0]))
    else report_mismatch("uop0", $sampled(exp_u_q[0]), $sampled(act_u0));

  a_uop1: assert property (@(posedge clk) (cycles > 1 && exp_v_q[1] && chk_u_q[1])
    |-> masked(act_u1, care_q[1]) == masked(exp_u_q[1], care_q[1]))
    else report_mismatch("uop1", $sampled(exp_u_q[1]), $sampled(act_u1));

  initial
  begin
    reg_addr_t a;
    slot0 = '0;
    slot1 = '0;
    slot0_valid = 1'b0;
    slot1_valid = 1'b0;
    fwd_old = '0;
    fwd_young = '0;
    exe_ready = 1'b1;
    flush = 1'b0;
    rng = 32'd94660;
    mism = 0;
    other = 0;
    exp_pop = '0;
    exp_v = '0;
    care = '0;
    chk_u = '0;
    next_care = '0;
    next_chk = '0;
    @(negedge rst);

    // independent pairs
    load_slot(0, K_ADDI, low_reg(), low_reg(), 0);
    load_slot(1, K_XOR, high_reg(), high_reg(), high_reg());
    drive_cycle(2'b11, 1'b0, 1'b1, 1'b0);
    load_slot(0, K_ADD, low_reg(), low_reg(), low_reg());
    load_slot(1, K_STH, high_reg(), high_reg(), 0);
    drive_cycle(2'b11, 1'b0, 1'b1, 1'b0);

    // young bus over old bus, then old bus alone, then register file
    a = high_reg();
    fwd_young = '{valid: 1'b1, gr_we: 1'b1, dest: a, data: xorshift()};
    fwd_old = '{valid: 1'b1, gr_we: 1'b1, dest: a, data: xorshift()};
    for (int i = 0; i < 3; i++)
    begin
      if (i == 1)
        fwd_young.valid = 1'b0;
      if (i == 2)
        fwd_old.valid = 1'b0;
      load_slot(0, K_ADDI, low_reg(), a, 0);
      load_slot(1, K_XOR, high_reg(), a, high_reg());
      drive_cycle(2'b11, 1'b0, 1'b1, 1'b0);
    end

    // single issue: raw, load, branch, two muls, unknown
    a = low_reg();
    load_slot(0, K_ADDI, a, low_reg(), 0);
    load_slot(1, K_ADD, high_reg(), a, high_reg());
    drive_cycle(2'b11, 1'b1, 1'b1, 1'b0);
    load_slot(0, K_LDW, low_reg(), low_reg(), 0);
    load_slot(1, K_XOR, high_reg(), high_reg(), high_reg());
    drive_cycle(2'b11, 1'b1, 1'b1, 1'b0);
    load_slot(0, K_BEQ, low_reg(), low_reg(), 0);
    load_slot(1, K_ADDI, high_reg(), high_reg(), 0);
    drive_cycle(2'b11, 1'b1, 1'b1, 1'b0);
    load_slot(0, K_MUL, low_reg(), low_reg(), low_reg());
    load_slot(1, K_MUL, high_reg(), high_reg(), high_reg());
    drive_cycle(2'b11, 1'b1, 1'b1, 1'b0);
    load_slot(0, K_ADDI, low_reg(), low_reg(), 0);
    load_slot(1, K_UNK, 0, 0, 0);
    drive_cycle(2'b11, 1'b1, 1'b1, 1'b0);

    // widths and branch flags, all alone in slot 0
    load_slot(1, K_ADDI, high_reg(), high_reg(), 0);
    load_slot(0, K_LDB, low_reg(), low_reg(), 0);
    drive_cycle(2'b11, 1'b1, 1'b1, 1'b0);
    load_slot(0, K_STW, low_reg(), low_reg(), 0);
    drive_cycle(2'b11, 1'b1, 1'b1, 1'b0);
    load_slot(0, K_BLT, low_reg(), low_reg(), 0);
    drive_cycle(2'b11, 1'b1, 1'b1, 1'b0);
    load_slot(0, K_BL, 0, 0, 0);
    drive_cycle(2'b11, 1'b1, 1'b1, 1'b0);

    // stall holds, flush clears even while stalled
    load_slot(0, K_ADDI, low_reg(), low_reg(), 0);
    load_slot(1, K_XOR, high_reg(), high_reg(), high_reg());
    drive_cycle(2'b11, 1'b0, 1'b1, 1'b0);
    load_slot(0, K_ADD, low_reg(), low_reg(), low_reg());
    load_slot(1, K_ADDI, high_reg(), high_reg(), 0);
    drive_cycle(2'b11, 1'b0, 1'b0, 1'b0);
    drive_cycle(2'b11, 1'b0, 1'b0, 1'b0);
    drive_cycle(2'b11, 1'b0, 1'b0, 1'b1);
    drive_cycle(2'b11, 1'b0, 1'b1, 1'b0);
    drive_cycle(2'b11, 1'b0, 1'b1, 1'b1);
    drive_cycle(2'b00, 1'b0, 1'b1, 1'b0);
    drive_cycle(2'b00, 1'b0, 1'b1, 1'b0);

    $display("errors: %0d mismatches, %0d other failures", mism, other);
    if (mism == 0 && other == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+common
common/isa_pkg.sv
common/pipe_pkg.sv
decode/operand_select.sv
decode/instr_decoder.sv
verilog/pair_check.sv
verilog/issue_stage.sv
test/tb_clock.sv
test/issue_stage_tb.sv

// File: Bender.yml
package:
  name: issue_stage

sources:
  - include_dirs:
      - common
    files:
      - common/isa_pkg.sv
      - common/pipe_pkg.sv
      - decode/operand_select.sv
      - decode/instr_decoder.sv
      - verilog/pair_check.sv
      - verilog/issue_stage.sv
  - target: test
    include_dirs:
      - common
    files:
      - test/tb_clock.sv
      - test/issue_stage_tb.sv
